// ==== logic/idiv_pkg.sv ====
package idiv_pkg;

  // ------------------------------
  // controller states
  // ------------------------------

  // one cycle each, except iterate which runs width_p+1 cycles
  typedef enum logic [3:0] {
    idle         = 4'd0,
    neg_divisor  = 4'd1,
    neg_dividend = 4'd2,
    shift_msb    = 4'd3,
    iterate      = 4'd4,
    repair       = 4'd5,
    neg_rem      = 4'd6,
    neg_quot     = 4'd7,
    done         = 4'd8
  } idiv_state_e;

  // ------------------------------
  // operand mux selects
  // ------------------------------

  // one-hot select width of the b and c muxes
  localparam int opsel_w = 3;

  // b mux: copy of c
  localparam logic [opsel_w-1:0] opb_sel_hold_c  = 3'b100;
  // b mux: adder result as is
  localparam logic [opsel_w-1:0] opb_sel_sum_c   = 3'b010;
  // b mux: adder result shifted left, msb of c enters at bit 0
  localparam logic [opsel_w-1:0] opb_sel_shift_c = 3'b001;

  // c mux: sign-extended dividend from the input latch
  localparam logic [opsel_w-1:0] opc_sel_load_c  = 3'b100;
  // c mux: adder result as is
  localparam logic [opsel_w-1:0] opc_sel_sum_c   = 3'b010;
  // c mux: c shifted left, inverted adder sign enters as quotient bit
  localparam logic [opsel_w-1:0] opc_sel_shift_c = 3'b001;

endpackage

// ==== logic/idiv_datapath.sv ====
`timescale 1ns/1ps

module idiv_datapath
  import idiv_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic [width_p-1:0] dividend_i,
  input  logic [width_p-1:0] divisor_i,
  input  logic               signed_div_i,

  input  logic               latch_inputs_i,

  input  logic               opa_sel_i,
  input  logic               opa_ld_i,
  input  logic               opa_inv_i,
  input  logic               opa_clr_n_i,

  input  logic [opsel_w-1:0] opb_sel_i,
  input  logic               opb_ld_i,
  input  logic               opb_inv_i,
  input  logic               opb_clr_n_i,

  input  logic [opsel_w-1:0] opc_sel_i,
  input  logic               opc_ld_i,

  input  logic               adder_cin_i,

  output logic               divisor_neg_o,
  output logic               dividend_neg_o,
  output logic               adder_neg_o,
  output logic               opa_neg_o,

  output logic [width_p-1:0] quotient_o,
  output logic [width_p-1:0] remainder_o
);

  // one guard bit above the data so magnitudes stay positive
  localparam int reg_w = width_p + 1;

  logic               signed_div_r;
  logic [width_p-1:0] dividend_r;
  logic [width_p-1:0] divisor_r;

  logic               divisor_msb;
  logic               dividend_msb;

  // a holds divisor then remainder, b the partial remainder,
  // c dividend then quotient
  logic [reg_w-1:0]   opa_r;
  logic [reg_w-1:0]   opb_r;
  logic [reg_w-1:0]   opc_r;

  logic [reg_w-1:0]   opa_mux;
  logic [reg_w-1:0]   opb_mux;
  logic [reg_w-1:0]   opc_mux;

  logic [reg_w-1:0]   add_in0;
  logic [reg_w-1:0]   add_in1;
  logic [reg_w-1:0]   add_out;

  // ------------------------------
  // input latches
  // ------------------------------

  // captured only on the accepting edge, stable for the whole division
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      signed_div_r <= 1'b0;
      dividend_r   <= '0;
      divisor_r    <= '0;
    end else if (latch_inputs_i) begin
      signed_div_r <= signed_div_i;
      dividend_r   <= dividend_i;
      divisor_r    <= divisor_i;
    end
  end

  // operand sign, only meaningful for signed division
  assign divisor_msb  = signed_div_r & divisor_r[width_p-1];
  assign dividend_msb = signed_div_r & dividend_r[width_p-1];

  // ------------------------------
  // operand muxes
  // ------------------------------

  // a: sign-extended divisor or adder result
  assign opa_mux = opa_sel_i ? add_out : {divisor_msb, divisor_r};

  always_comb begin
    case (opb_sel_i)
      opb_sel_hold_c:  opb_mux = opc_r;
      opb_sel_sum_c:   opb_mux = add_out;
      // next dividend bit comes from the top of c
      opb_sel_shift_c: opb_mux = {add_out[reg_w-2:0], opc_r[reg_w-1]};
      default:         opb_mux = opb_r;
    endcase
  end

  always_comb begin
    case (opc_sel_i)
      opc_sel_load_c:  opc_mux = {dividend_msb, dividend_r};
      opc_sel_sum_c:   opc_mux = add_out;
      // quotient bit is one when the step result is non-negative
      opc_sel_shift_c: opc_mux = {opc_r[reg_w-2:0], ~add_out[reg_w-1]};
      default:         opc_mux = opc_r;
    endcase
  end

  // ------------------------------
  // operand registers
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      opa_r <= '0;
      opb_r <= '0;
      opc_r <= '0;
    end else begin
      if (opa_ld_i) begin
        opa_r <= opa_mux;
      end
      if (opb_ld_i) begin
        opb_r <= opb_mux;
      end
      if (opc_ld_i) begin
        opc_r <= opc_mux;
      end
    end
  end

  // ------------------------------
  // shared adder
  // ------------------------------

  // invert then clear each side, so with cin one adder can
  // pass, negate, add or subtract
  assign add_in0 = (opa_r ^ {reg_w{opa_inv_i}}) & {reg_w{opa_clr_n_i}};
  assign add_in1 = (opb_r ^ {reg_w{opb_inv_i}}) & {reg_w{opb_clr_n_i}};

  assign add_out = add_in0 + add_in1 + reg_w'(adder_cin_i);

  // status back to the controller
  assign divisor_neg_o  = divisor_msb;
  assign dividend_neg_o = dividend_msb;
  assign adder_neg_o    = add_out[reg_w-1];
  assign opa_neg_o      = opa_r[reg_w-1];

  // results on the low data bits
  assign quotient_o  = opc_r[width_p-1:0];
  assign remainder_o = opa_r[width_p-1:0];

endmodule

// ==== logic/idiv_controller.sv ====
`timescale 1ns/1ps

module idiv_controller
  import idiv_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               v_i,
  output logic               ready_o,

  output logic               v_o,
  input  logic               yumi_i,

  input  logic               divisor_neg_i,
  input  logic               dividend_neg_i,
  input  logic               adder_neg_i,
  input  logic               opa_neg_i,

  output logic               latch_inputs_o,

  output logic               opa_sel_o,
  output logic               opa_ld_o,
  output logic               opa_inv_o,
  output logic               opa_clr_n_o,

  output logic [opsel_w-1:0] opb_sel_o,
  output logic               opb_ld_o,
  output logic               opb_inv_o,
  output logic               opb_clr_n_o,

  output logic [opsel_w-1:0] opc_sel_o,
  output logic               opc_ld_o,

  output logic               adder_cin_o
);

  // counts width_p+1 iterate cycles, 0 .. width_p
  localparam int cnt_w = $clog2(width_p + 1);

  idiv_state_e state_r;
  idiv_state_e state_nxt;

  logic [cnt_w-1:0] cnt_r;
  logic             last_iter;

  // accepted request waiting for its operand load cycle
  logic             load_r;
  // sign of the previous step result, picks add or subtract
  logic             step_neg_r;
  logic             quot_neg_r;
  logic             rem_neg_r;

  assign last_iter = (cnt_r == cnt_w'(width_p));

  // idle and no load pending
  assign ready_o        = (state_r == idle) && !load_r;
  assign latch_inputs_o = ready_o && v_i;
  assign v_o            = (state_r == done);

  // ------------------------------
  // state register
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= idle;
      load_r     <= 1'b0;
      cnt_r      <= '0;
      step_neg_r <= 1'b0;
      quot_neg_r <= 1'b0;
      rem_neg_r  <= 1'b0;
    end else begin
      state_r <= state_nxt;
      load_r  <= latch_inputs_o;
      // signs are final once the latches are loaded
      if (load_r) begin
        quot_neg_r <= divisor_neg_i ^ dividend_neg_i;
        rem_neg_r  <= dividend_neg_i;
      end
      // first step always subtracts
      if (state_r == shift_msb) begin
        cnt_r      <= '0;
        step_neg_r <= 1'b0;
      end
      if (state_r == iterate) begin
        cnt_r      <= cnt_r + 1'b1;
        step_neg_r <= adder_neg_i;
      end
    end
  end

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      idle:         if (load_r) state_nxt = neg_divisor;
      neg_divisor:  state_nxt = neg_dividend;
      neg_dividend: state_nxt = shift_msb;
      shift_msb:    state_nxt = iterate;
      iterate:      if (last_iter) state_nxt = repair;
      repair:       state_nxt = neg_rem;
      neg_rem:      state_nxt = neg_quot;
      neg_quot:     state_nxt = done;
      done:         if (yumi_i) state_nxt = idle;
      default:      state_nxt = idle;
    endcase
  end

  // ------------------------------
  // datapath controls
  // ------------------------------

  always_comb begin
    // default: hold everything, adder passes zero
    opa_sel_o   = 1'b0;
    opa_ld_o    = 1'b0;
    opa_inv_o   = 1'b0;
    opa_clr_n_o = 1'b0;
    opb_sel_o   = opb_sel_hold_c;
    opb_ld_o    = 1'b0;
    opb_inv_o   = 1'b0;
    opb_clr_n_o = 1'b0;
    opc_sel_o   = opc_sel_load_c;
    opc_ld_o    = 1'b0;
    adder_cin_o = 1'b0;

    case (state_r)
      idle: begin
        // load cycle: divisor into a, dividend into c
        if (load_r) begin
          opa_ld_o = 1'b1;
          opc_ld_o = 1'b1;
        end
      end

      neg_divisor: begin
        // a <= -a when the divisor is negative
        opa_sel_o   = 1'b1;
        opa_ld_o    = opa_neg_i;
        opa_inv_o   = 1'b1;
        opa_clr_n_o = 1'b1;
        adder_cin_o = 1'b1;
        // copy dividend to b for its negation
        opb_sel_o   = opb_sel_hold_c;
        opb_ld_o    = 1'b1;
      end

      neg_dividend: begin
        // c <= -b when the dividend is negative
        opb_inv_o   = 1'b1;
        opb_clr_n_o = 1'b1;
        adder_cin_o = 1'b1;
        opc_sel_o   = opc_sel_sum_c;
        opc_ld_o    = dividend_neg_i;
      end

      shift_msb: begin
        // adder is zero, so b takes just the msb of c
        opb_sel_o = opb_sel_shift_c;
        opb_ld_o  = 1'b1;
        opc_sel_o = opc_sel_shift_c;
        opc_ld_o  = 1'b1;
      end

      iterate: begin
        // b - a after a non-negative step, b + a otherwise
        opa_clr_n_o = 1'b1;
        opa_inv_o   = !step_neg_r;
        adder_cin_o = !step_neg_r;
        opb_clr_n_o = 1'b1;
        // last step keeps the remainder unshifted
        opb_sel_o   = last_iter ? opb_sel_sum_c : opb_sel_shift_c;
        opb_ld_o    = 1'b1;
        opc_sel_o   = opc_sel_shift_c;
        opc_ld_o    = 1'b1;
      end

      repair: begin
        // a <= b, plus the divisor when the remainder went negative
        opa_sel_o   = 1'b1;
        opa_ld_o    = 1'b1;
        opa_clr_n_o = step_neg_r;
        opb_clr_n_o = 1'b1;
        // quotient to b for the final negation
        opb_sel_o   = opb_sel_hold_c;
        opb_ld_o    = 1'b1;
      end

      neg_rem: begin
        // remainder follows the dividend sign
        opa_sel_o   = 1'b1;
        opa_ld_o    = rem_neg_r;
        opa_inv_o   = 1'b1;
        opa_clr_n_o = 1'b1;
        adder_cin_o = 1'b1;
      end

      neg_quot: begin
        // c <= -b when exactly one operand was negative
        opb_inv_o   = 1'b1;
        opb_clr_n_o = 1'b1;
        adder_cin_o = 1'b1;
        opc_sel_o   = opc_sel_sum_c;
        opc_ld_o    = quot_neg_r;
      end

      default: begin
        // done: registers hold the result
      end
    endcase
  end

endmodule

// ==== logic/idiv_iterative.sv ====
`timescale 1ns/1ps

module idiv_iterative
  import idiv_pkg::*;
#(
  parameter int width_p = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               v_i,
  output logic               ready_o,

  input  logic [width_p-1:0] dividend_i,
  input  logic [width_p-1:0] divisor_i,
  input  logic               signed_div_i,

  output logic               v_o,
  output logic [width_p-1:0] quotient_o,
  output logic [width_p-1:0] remainder_o,
  input  logic               yumi_i
);

  // ------------------------------
  // controller to datapath
  // ------------------------------

  logic               latch_inputs;
  logic               opa_sel;
  logic               opa_ld;
  logic               opa_inv;
  logic               opa_clr_n;
  logic [opsel_w-1:0] opb_sel;
  logic               opb_ld;
  logic               opb_inv;
  logic               opb_clr_n;
  logic [opsel_w-1:0] opc_sel;
  logic               opc_ld;
  logic               adder_cin;

  // status back to the controller
  logic               divisor_neg;
  logic               dividend_neg;
  logic               adder_neg;
  logic               opa_neg;

  idiv_datapath #(
    .width_p (width_p)
  ) i_datapath (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .signed_div_i   (signed_div_i),
    .latch_inputs_i (latch_inputs),
    .opa_sel_i      (opa_sel),
    .opa_ld_i       (opa_ld),
    .opa_inv_i      (opa_inv),
    .opa_clr_n_i    (opa_clr_n),
    .opb_sel_i      (opb_sel),
    .opb_ld_i       (opb_ld),
    .opb_inv_i      (opb_inv),
    .opb_clr_n_i    (opb_clr_n),
    .opc_sel_i      (opc_sel),
    .opc_ld_i       (opc_ld),
    .adder_cin_i    (adder_cin),
    .divisor_neg_o  (divisor_neg),
    .dividend_neg_o (dividend_neg),
    .adder_neg_o    (adder_neg),
    .opa_neg_o      (opa_neg),
    .quotient_o     (quotient_o),
    .remainder_o    (remainder_o)
  );

  idiv_controller #(
    .width_p (width_p)
  ) i_controller (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .v_i            (v_i),
    .ready_o        (ready_o),
    .v_o            (v_o),
    .yumi_i         (yumi_i),
    .divisor_neg_i  (divisor_neg),
    .dividend_neg_i (dividend_neg),
    .adder_neg_i    (adder_neg),
    .opa_neg_i      (opa_neg),
    .latch_inputs_o (latch_inputs),
    .opa_sel_o      (opa_sel),
    .opa_ld_o       (opa_ld),
    .opa_inv_o      (opa_inv),
    .opa_clr_n_o    (opa_clr_n),
    .opb_sel_o      (opb_sel),
    .opb_ld_o       (opb_ld),
    .opb_inv_o      (opb_inv),
    .opb_clr_n_o    (opb_clr_n),
    .opc_sel_o      (opc_sel),
    .opc_ld_o       (opc_ld),
    .adder_cin_o    (adder_cin)
  );

endmodule

// ==== verif/idiv_tb_model.svh ====
`ifndef idiv_tb_model_svh
`define idiv_tb_model_svh

// ------------------------------
// reference model
// ------------------------------

// divide magnitudes unsigned, then put the signs back
function automatic void divide_ref(
  input  logic [width_p-1:0] dividend,
  input  logic [width_p-1:0] divisor,
  input  logic               signed_div,
  output logic [width_p-1:0] quot,
  output logic [width_p-1:0] rem
);
  logic               dividend_neg;
  logic               divisor_neg;
  logic [width_p-1:0] dividend_mag;
  logic [width_p-1:0] divisor_mag;
  logic [width_p-1:0] quot_mag;
  logic [width_p-1:0] rem_mag;
  dividend_neg = signed_div & dividend[width_p-1];
  divisor_neg  = signed_div & divisor[width_p-1];
  // most-negative maps onto itself, already the right unsigned magnitude
  dividend_mag = dividend_neg ? -dividend : dividend;
  divisor_mag  = divisor_neg ? -divisor : divisor;
  if (divisor_mag == '0) begin
    // zero divisor: all-ones quotient, dividend magnitude as remainder
    quot_mag = '1;
    rem_mag  = dividend_mag;
  end else begin
    quot_mag = dividend_mag / divisor_mag;
    rem_mag  = dividend_mag % divisor_mag;
  end
  // quotient negative for mixed signs, remainder follows the dividend
  quot = (dividend_neg ^ divisor_neg) ? -quot_mag : quot_mag;
  rem  = dividend_neg ? -rem_mag : rem_mag;
endfunction

// ------------------------------
// result compares
// ------------------------------

task automatic check_quotient(
  input logic [width_p-1:0] got,
  input logic [width_p-1:0] exp,
  input string              ctx
);
  if (got !== exp) begin
    report_error($sformatf("quotient %h, expected %h (%s)", got, exp, ctx));
  end
endtask

task automatic check_remainder(
  input logic [width_p-1:0] got,
  input logic [width_p-1:0] exp,
  input string              ctx
);
  if (got !== exp) begin
    report_error($sformatf("remainder %h, expected %h (%s)", got, exp, ctx));
  end
endtask

`endif

// ==== verif/idiv_tb.sv ====
`timescale 1ns/1ps

module idiv_tb
  import idiv_pkg::*;
();

  localparam int width_p        = 32;
  localparam int num_random     = 400;
  localparam int num_corner     = 14;
  localparam int num_tests      = num_random + num_corner;
  localparam int max_yumi_delay = 20;
  localparam int reset_cycles   = 16;
  // per division latency plus longest yumi delay and handshake slack
  localparam int timeout_cycles =
    num_tests * (width_p + 8 + max_yumi_delay + 4) + reset_cycles;

  localparam logic [width_p-1:0] most_neg = {1'b1, {(width_p-1){1'b0}}};
  localparam logic [width_p-1:0] all_ones = '1;

  logic               clk_i;
  logic               arst_n_i;
  logic               v_i;
  logic               ready_o;
  logic [width_p-1:0] dividend_i;
  logic [width_p-1:0] divisor_i;
  logic               signed_div_i;
  logic               v_o;
  logic [width_p-1:0] quotient_o;
  logic [width_p-1:0] remainder_o;
  logic               yumi_i;

  // controller state for error messages
  idiv_state_e        dbg_state;

  assign dbg_state = i_dut.i_controller.state_r;

  idiv_iterative #(
    .width_p (width_p)
  ) i_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .signed_div_i (signed_div_i),
    .v_o          (v_o),
    .quotient_o   (quotient_o),
    .remainder_o  (remainder_o),
    .yumi_i       (yumi_i)
  );

  // ------------------------------
  // clock and watchdog
  // ------------------------------

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("watchdog expired: the divisions did not complete in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------
  // checks
  // ------------------------------

  task automatic report_error(input string msg);
    $display("Error at %0t: %s [state %s]", $time, msg, dbg_state.name());
    $display("Result: FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  `include "idiv_tb_model.svh"

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_latency(input int got, input string ctx);
    if (got != width_p + 8) begin
      report_error($sformatf("v_o rose %0d edges after acceptance, expected %0d (%s)",
                             got, width_p + 8, ctx));
    end
  endtask

  // ------------------------------
  // one division
  // ------------------------------

  // starts just after a falling edge with the DUT idle
  task automatic run_division(
    input logic [width_p-1:0] dividend,
    input logic [width_p-1:0] divisor,
    input logic               sgn
  );
    logic [width_p-1:0] exp_q;
    logic [width_p-1:0] exp_r;
    logic [width_p-1:0] held_q;
    logic [width_p-1:0] held_r;
    int                 edges;
    int                 delay;
    string              ctx;
    ctx = $sformatf("%h / %h signed %b", dividend, divisor, sgn);
    divide_ref(dividend, divisor, sgn, exp_q, exp_r);
    v_i          = 1'b1;
    dividend_i   = dividend;
    divisor_i    = divisor;
    signed_div_i = sgn;
    @(negedge clk_i);
    // count edges from the accepting edge until v_o
    edges = 0;
    while (v_o !== 1'b1 && edges <= width_p + 8) begin
      check_level("ready_o while busy", ready_o, 1'b0);
      // stray requests and new operands must not disturb the division
      v_i          = 1'($urandom_range(0, 1));
      dividend_i   = width_p'($urandom());
      divisor_i    = width_p'($urandom());
      signed_div_i = 1'($urandom_range(0, 1));
      @(negedge clk_i);
      edges++;
    end
    check_latency(edges, ctx);
    check_quotient(quotient_o, exp_q, ctx);
    check_remainder(remainder_o, exp_r, ctx);
    held_q = quotient_o;
    held_r = remainder_o;
    // back-pressure with a request offered the whole time
    delay = $urandom_range(0, max_yumi_delay);
    repeat (delay) begin
      v_i        = 1'b1;
      dividend_i = width_p'($urandom());
      divisor_i  = width_p'($urandom());
      @(negedge clk_i);
      check_level("v_o under back-pressure", v_o, 1'b1);
      check_level("ready_o under back-pressure", ready_o, 1'b0);
      check_quotient(quotient_o, held_q, ctx);
      check_remainder(remainder_o, held_r, ctx);
    end
    v_i    = 1'b0;
    yumi_i = 1'b1;
    @(negedge clk_i);
    yumi_i = 1'b0;
    check_level("v_o after yumi", v_o, 1'b0);
    check_level("ready_o after yumi", ready_o, 1'b1);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin : main
    logic [width_p-1:0] a;
    logic [width_p-1:0] b;
    int unsigned        seed;
    seed = 64512;
    void'($urandom(seed));
    arst_n_i     = 1'b0;
    v_i          = 1'b0;
    yumi_i       = 1'b0;
    dividend_i   = '0;
    divisor_i    = '0;
    signed_div_i = 1'b0;
    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_level("ready_o after reset", ready_o, 1'b1);
    check_level("v_o after reset", v_o, 1'b0);

    // corner operands
    run_division(width_p'(100), '0, 1'b0);
    run_division(width_p'(-100), '0, 1'b1);
    run_division('0, '0, 1'b1);
    run_division(most_neg, all_ones, 1'b1);
    run_division(most_neg, all_ones, 1'b0);
    run_division(width_p'(12345), width_p'(1), 1'b1);
    run_division(width_p'(-12345), width_p'(1), 1'b1);
    run_division(most_neg, width_p'(1), 1'b1);
    run_division(width_p'(7), width_p'(100), 1'b0);
    run_division(width_p'(-7), width_p'(100), 1'b1);
    run_division(width_p'(7), width_p'(-100), 1'b1);
    run_division(all_ones, all_ones, 1'b1);
    run_division(all_ones, all_ones, 1'b0);
    run_division(all_ones, width_p'(1), 1'b0);

    // random operands with divisors spread over several magnitudes
    for (int i = 0; i < num_random; i++) begin
      a = width_p'($urandom());
      case ($urandom_range(0, 3))
        0: b = width_p'($urandom());
        1: b = width_p'($urandom_range(0, 255));
        2: b = -width_p'($urandom_range(1, 255));
        default: b = width_p'($urandom()) >> $urandom_range(0, width_p - 1);
      endcase
      run_division(a, b, 1'($urandom_range(0, 1)));
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verif
logic/idiv_pkg.sv
logic/idiv_datapath.sv
logic/idiv_controller.sv
logic/idiv_iterative.sv
verif/idiv_tb.sv
